// ==== myo_control.f ====
+incdir+src
src/myo_pkg.sv
src/myo_reg_bank.sv
src/scan_sequencer.sv
src/spi_frame_link.sv
src/pi_controller.sv
src/myo_control.sv
tb/tb_clock_gen.sv
tb/motor_board_model.sv
tb/myo_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the motor control testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module myo_control_tb -f myo_control.f -o sim_myo_control

./obj_dir/sim_myo_control > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// ==== tb/myo_control_tb.sv ====
// testbench top of the motor control core
// register access, scan order, PI results, controller clear and update period
// with a reference PI model, a frame monitor and a watchdog
`timescale 1ns/1ps
`include "myo_params.svh"

module myo_control_tb;
	import myo_pkg::*;

	localparam int N = `MYO_NUM_MOTORS;
	localparam int PERIOD = 600;
	// each frame with its gap takes about 130 cycles over all scan runs
	localparam int TOTAL_FRAMES = 3 * N + 3 * N + 5 * N + 3 * N;
	localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES * 130 + 5 * PERIOD + 3000) * 8;

	logic clock;
	logic reset;
	bus_req_t bus;
	logic miso;
	logic [31:0] readdata;
	logic read_valid;
	logic [N-1:0] ss_n;
	logic sck;
	logic mosi;
	logic [N-1:0][31:0] pos_table;

	int seed = 32'hf870_f20e;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	// controller settings of each motor for the control tests
	int kp [N];
	int ki [N];
	int sp [N];
	int opm [N];
	int onm [N];
	int ipm [N];
	int inm [N];
	int db [N];
	int pos [N];
	int base [N];
	// frame monitor results
	int cyc = 0;
	int mon_frames = 0;
	int frame_motor [256];
	int fall_cnt = 0;
	int fall_cycle [64];

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) clkgen0 (
		.clock_o(clock),
		.reset_o(reset)
	);

	motor_board_model #(.NUM_MOTORS(N)) board0 (
		.clock(clock),
		.reset(reset),
		.ss_n_i(ss_n),
		.sck_i(sck),
		.mosi_i(mosi),
		.pos_table_i(pos_table),
		.miso_o(miso)
	);

	myo_control dut0 (
		.clock(clock),
		.reset(reset),
		.bus_i(bus),
		.miso_i(miso),
		.readdata_o(readdata),
		.read_valid_o(read_valid),
		.ss_n_o(ss_n),
		.sck_o(sck),
		.mosi_o(mosi)
	);

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// expected PWM after k updates from a zero integral with the position held constant
	function automatic longint ref_pwm(input int m, input int k);
		longint err;
		longint integ;
		longint outv;
		longint sum;
		integ = 0;
		outv = 0;
		for (int i = 0; i < k; i++) begin
			err = longint'(sp[m]) - longint'(pos[m]);
			if ((err < 0 ? -err : err) <= db[m]) err = 0;
			integ = integ + err;
			if (integ > ipm[m]) integ = ipm[m];
			else if (integ < inm[m]) integ = inm[m];
			sum = longint'(kp[m]) * err + longint'(ki[m]) * integ;
			outv = sum >>> `MYO_GAIN_SHIFT;
			if (outv > opm[m]) outv = opm[m];
			else if (outv < onm[m]) outv = onm[m];
		end
		return outv;
	endfunction

	task automatic bus_write(input logic [7:0] sel, input logic [7:0] motor, input logic [31:0] data);
		@(posedge clock);
		bus.write <= 1'b1;
		bus.address <= {sel, motor};
		bus.writedata <= data;
		@(posedge clock);
		bus.write <= 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] sel, input logic [7:0] motor, output logic [31:0] data);
		@(posedge clock);
		bus.read <= 1'b1;
		bus.address <= {sel, motor};
		@(posedge clock);
		bus.read <= 1'b0;
		// the answer belongs to the cycle right after the strobe
		@(negedge clock);
		check_value($sformatf("read_valid sel %h m%0d", sel, motor), {31'b0, read_valid}, 32'd1);
		data = readdata;
	endtask

	// scan stops after the frame in flight and then the lines stay quiet
	task automatic stop_scan();
		int quiet;
		bus_write(`MYO_SEL_SCAN_ENABLE, 8'd0, 32'd0);
		repeat (4) @(negedge clock);
		quiet = 0;
		while (quiet < 3) begin
			@(negedge clock);
			if (ss_n == '1) quiet++;
			else quiet = 0;
		end
	endtask

	task automatic run_frames(input int extra);
		int target;
		target = board0.frame_cnt[N-1] + extra;
		bus_write(`MYO_SEL_SCAN_ENABLE, 8'd0, 32'd1);
		// scan is switched off while the last motor of the final round is selected
		while (board0.frame_cnt[N-1] < target - 1 || ss_n[N-1]) @(negedge clock);
		stop_scan();
	endtask

	// checks the recorded PWM of every frame and then the PWM and position registers
	task automatic check_motor(input int m);
		logic [31:0] rd;
		longint e;
		for (int r = base[m]; r < board0.frame_cnt[m]; r++) begin
			e = ref_pwm(m, r - base[m]);
			check_value($sformatf("model pwm m%0d frame %0d", m, r),
				{16'b0, board0.pwm_rec[m][r]}, {16'b0, e[15:0]});
		end
		bus_read(`MYO_SEL_PWM, 8'(m), rd);
		check_value($sformatf("pwm m%0d", m), rd, 32'(ref_pwm(m, board0.frame_cnt[m] - base[m])));
		bus_read(`MYO_SEL_POSITION, 8'(m), rd);
		check_value($sformatf("position m%0d", m), rd, pos_table[m]);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - errs_before);
	endtask

	// watches every frame on the SPI lines
	always @(negedge clock) begin : frame_monitor
		static logic in_low = 1'b0;
		static logic sck_prev = 1'b0;
		static int low_len = 0;
		static int pulses = 0;
		static int cur_m = 0;
		cyc++;
		if (!reset) begin
			if (ss_n != '1) begin
				if ($countones(~ss_n) > 1) begin
					errors++;
					$display("more than one motor board selected at %0t ns", $time);
				end
				if (!in_low) begin
					in_low = 1'b1;
					low_len = 0;
					pulses = 0;
					for (int m = 0; m < N; m++) if (!ss_n[m]) cur_m = m;
					if (cur_m == 0 && fall_cnt < 64) begin
						fall_cycle[fall_cnt] = cyc;
						fall_cnt++;
					end
				end
				low_len++;
				if (sck && !sck_prev) pulses++;
			end else if (in_low) begin
				in_low = 1'b0;
				check_value($sformatf("select low cycles m%0d", cur_m), low_len, 32'd128);
				check_value($sformatf("sck pulses m%0d", cur_m), pulses, 32'd32);
				if (mon_frames < 256) frame_motor[mon_frames] = cur_m;
				mon_frames++;
			end
			sck_prev = sck;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired, the scan did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main
		logic [31:0] rd;
		logic [31:0] wr;
		logic [31:0] exp_rd [N][8];
		int eb;
		int fb;
		int offs [N];
		bus = '0;
		pos_table = '0;
		offs[0] = 5;
		offs[1] = 30000;
		offs[2] = 300;
		offs[3] = -200;
		@(negedge reset);
		repeat (2) @(negedge clock);

		eb = errors;
		check_value("ss_n", {28'b0, ss_n}, 32'hf);
		check_value("sck", {31'b0, sck}, 32'd0);
		check_value("read_valid", {31'b0, read_valid}, 32'd0);
		for (int m = 0; m < N; m++) begin
			bus_read(`MYO_SEL_PWM, 8'(m), rd);
			check_value($sformatf("pwm m%0d", m), rd, 32'd0);
			bus_read(`MYO_SEL_POSITION, 8'(m), rd);
			check_value($sformatf("position m%0d", m), rd, 32'd0);
		end
		end_test("reset", eb);

		eb = errors;
		for (int m = 0; m < N; m++) begin
			for (int s = 0; s < 8; s++) begin
				wr = $random(seed);
				bus_write(8'(s), 8'(m), wr);
				// only the setpoint is a full word
				exp_rd[m][s] = (s == 2) ? wr : {{16{wr[15]}}, wr[15:0]};
			end
		end
		bus_write(`MYO_SEL_KP, 8'd4, 32'h1234);
		bus_write(`MYO_SEL_SP, 8'd7, 32'h5555_0000);
		for (int m = 0; m < N; m++) begin
			for (int s = 0; s < 8; s++) begin
				bus_read(8'(s), 8'(m), rd);
				check_value($sformatf("setting %0d m%0d", s, m), rd, exp_rd[m][s]);
			end
		end
		bus_read(8'h0C, 8'd0, rd);
		check_value("unknown select", rd, `MYO_BAD_READ);
		bus_read(`MYO_SEL_KP, 8'd5, rd);
		check_value("motor out of range", rd, `MYO_BAD_READ);
		end_test("register access", eb);

		// motor 0 sits in the deadband, motor 1 saturates, 2 and 3 clamp the integral
		for (int m = 0; m < N; m++) begin
			pos[m] = $signed($random(seed)) % 2000;
			pos_table[m] = pos[m];
			sp[m] = pos[m] + offs[m];
			kp[m] = 1 + ($random(seed) & 63);
			ki[m] = 1 + ($random(seed) & 15);
			opm[m] = (m == 1) ? 1000 : 20000;
			onm[m] = (m == 1) ? -1000 : -20000;
			ipm[m] = 500;
			inm[m] = -500;
			db[m] = (m == 0) ? 10 : 3;
			base[m] = 0;
			bus_write(`MYO_SEL_KP, 8'(m), kp[m]);
			bus_write(`MYO_SEL_KI, 8'(m), ki[m]);
			bus_write(`MYO_SEL_SP, 8'(m), sp[m]);
			bus_write(`MYO_SEL_OUT_POS_MAX, 8'(m), opm[m]);
			bus_write(`MYO_SEL_OUT_NEG_MAX, 8'(m), onm[m]);
			bus_write(`MYO_SEL_INT_POS_MAX, 8'(m), ipm[m]);
			bus_write(`MYO_SEL_INT_NEG_MAX, 8'(m), inm[m]);
			bus_write(`MYO_SEL_DEADBAND, 8'(m), db[m]);
		end
		eb = errors;
		run_frames(3);
		check_value("frames seen", mon_frames, 3 * N);
		for (int i = 0; i < mon_frames && i < 256; i++) begin
			check_value($sformatf("frame %0d motor", i), frame_motor[i], i % N);
		end
		end_test("scan order", eb);

		eb = errors;
		for (int m = 0; m < N; m++) check_motor(m);
		end_test("control result", eb);

		eb = errors;
		bus_write(`MYO_SEL_CTRL_RESET, 8'd2, 32'd1);
		base[2] = board0.frame_cnt[2];
		for (int m = 0; m < N; m++) begin
			bus_read(`MYO_SEL_PWM, 8'(m), rd);
			check_value($sformatf("pwm after clear m%0d", m), rd,
				32'(ref_pwm(m, board0.frame_cnt[m] - base[m])));
		end
		run_frames(3);
		for (int m = 0; m < N; m++) check_motor(m);
		end_test("controller reset", eb);

		eb = errors;
		bus_write(`MYO_SEL_UPDATE_PERIOD, 8'd0, PERIOD);
		fb = fall_cnt;
		bus_write(`MYO_SEL_SCAN_ENABLE, 8'd0, 32'd1);
		while (fall_cnt < fb + 4) @(negedge clock);
		stop_scan();
		for (int i = fb + 1; i < fb + 4; i++) begin
			check_value($sformatf("motor 0 start spacing %0d", i - fb), fall_cycle[i] - fall_cycle[i-1],
				PERIOD);
		end
		end_test("update period", eb);

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/motor_board_model.sv ====
// SPI slave model of the motor boards
// answers each frame with the selected motor's position from a table
// and records the upper 16 bits received on MOSI, per motor and frame
`timescale 1ns/1ps

module motor_board_model #(
	parameter int NUM_MOTORS = 4,
	parameter int MAX_FRAMES = 64
) (
	input  logic clock,
	input  logic reset,
	input  logic [NUM_MOTORS-1:0] ss_n_i,
	input  logic sck_i,
	input  logic mosi_i,
	input  logic [NUM_MOTORS-1:0][31:0] pos_table_i,
	output logic miso_o
);
	logic in_frame;
	logic sck_q;
	int cur_motor;
	logic [31:0] tx_sr;
	logic [31:0] rx_sr;
	logic [15:0] pwm_rec [NUM_MOTORS][MAX_FRAMES];
	int frame_cnt [NUM_MOTORS];

	// the board looks at the lines half a clock after the master moves them
	always @(negedge clock or posedge reset) begin
		if (reset) begin
			in_frame <= 1'b0;
			sck_q <= 1'b0;
			miso_o <= 1'b0;
			cur_motor <= 0;
			tx_sr <= '0;
			rx_sr <= '0;
			for (int m = 0; m < NUM_MOTORS; m++) begin
				frame_cnt[m] <= 0;
			end
		end else begin
			sck_q <= sck_i;
			if (in_frame && ss_n_i == '1) begin
				// select released, so the frame is complete
				in_frame <= 1'b0;
				if (frame_cnt[cur_motor] < MAX_FRAMES) begin
					pwm_rec[cur_motor][frame_cnt[cur_motor]] <= rx_sr[31:16];
				end
				frame_cnt[cur_motor] <= frame_cnt[cur_motor] + 1;
			end else if (!in_frame && ss_n_i != '1) begin
				in_frame <= 1'b1;
				for (int m = 0; m < NUM_MOTORS; m++) begin
					if (!ss_n_i[m]) begin
						cur_motor <= m;
						miso_o <= pos_table_i[m][31];
						tx_sr <= {pos_table_i[m][30:0], 1'b0};
					end
				end
			end else if (in_frame) begin
				if (sck_q && !sck_i) begin
					miso_o <= tx_sr[31];
					tx_sr <= {tx_sr[30:0], 1'b0};
				end
				if (!sck_q && sck_i) begin
					rx_sr <= {rx_sr[30:0], mosi_i};
				end
			end
		end
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
// testbench clock and reset generator
// free running clock and an active high reset held for a few rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clock_o,
	output logic reset_o
);
	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clock_o = ~clock_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== src/myo_control.sv ====
// top level of the motor control core
// host register bank, scan sequencer, SPI frame link
// and one PI controller per motor
`timescale 1ns/1ps
`include "myo_params.svh"

module myo_control (
	input  logic clock,
	input  logic reset,
	input  myo_pkg::bus_req_t bus_i,
	input  logic miso_i,
	output logic [31:0] readdata_o,
	output logic read_valid_o,
	output logic [`MYO_NUM_MOTORS-1:0] ss_n_o,
	output logic sck_o,
	output logic mosi_o
);
	import myo_pkg::*;

	pi_settings_t [`MYO_NUM_MOTORS-1:0] settings;
	motor_state_t [`MYO_NUM_MOTORS-1:0] state;
	logic [`MYO_NUM_MOTORS-1:0] ctrl_clear;
	logic [`MYO_NUM_MOTORS-1:0] update;
	logic scan_enable;
	logic [31:0] update_period;
	logic start;
	logic frame_done;
	logic [`MYO_MOTOR_W-1:0] motor;
	logic [`MYO_FRAME_W-1:0] tx_word;
	logic signed [`MYO_POS_W-1:0] rx_position;

	myo_reg_bank u_reg_bank (
		.clock(clock),
		.reset(reset),
		.bus_i(bus_i),
		.state_i(state),
		.readdata_o(readdata_o),
		.read_valid_o(read_valid_o),
		.settings_o(settings),
		.ctrl_clear_o(ctrl_clear),
		.scan_enable_o(scan_enable),
		.update_period_o(update_period)
	);

	scan_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.scan_enable_i(scan_enable),
		.update_period_i(update_period),
		.frame_done_i(frame_done),
		.state_i(state),
		.start_o(start),
		.motor_o(motor),
		.tx_word_o(tx_word),
		.update_o(update)
	);

	spi_frame_link u_link (
		.clock(clock),
		.reset(reset),
		.start_i(start),
		.motor_i(motor),
		.tx_word_i(tx_word),
		.miso_i(miso_i),
		.ss_n_o(ss_n_o),
		.sck_o(sck_o),
		.mosi_o(mosi_o),
		.frame_done_o(frame_done),
		.rx_position_o(rx_position)
	);

	// every controller sees the shared received position,
	// only the one whose update bit is set takes it
	for (genvar g = 0; g < `MYO_NUM_MOTORS; g++) begin : g_pi
		pi_controller u_pi (
			.clock(clock),
			.reset(reset),
			.clear_i(ctrl_clear[g]),
			.update_i(update[g]),
			.settings_i(settings[g]),
			.position_i(rx_position),
			.state_o(state[g])
		);
	end

endmodule

// ==== src/pi_controller.sv ====
// per-motor PI controller
// deadband on the error, clamped integral, shifted and clamped output
`timescale 1ns/1ps
`include "myo_params.svh"

module pi_controller (
	input  logic clock,
	input  logic reset,
	input  logic clear_i,
	input  logic update_i,
	input  myo_pkg::pi_settings_t settings_i,
	input  logic signed [`MYO_POS_W-1:0] position_i,
	output myo_pkg::motor_state_t state_o
);
	// wide enough that kp times the 33 bit error never overflows
	localparam int ACC_W = 64;

	logic signed [`MYO_PARAM_W-1:0] integ_q;
	logic signed [ACC_W-1:0] err_raw;
	logic signed [ACC_W-1:0] err_mag;
	logic signed [ACC_W-1:0] err;
	logic signed [ACC_W-1:0] integ_sum;
	logic signed [ACC_W-1:0] integ_new;
	logic signed [ACC_W-1:0] out_sum;
	logic signed [ACC_W-1:0] out_shift;
	logic signed [ACC_W-1:0] out_new;

	always_comb begin
		err_raw = settings_i.sp - position_i;
		err_mag = (err_raw < 0) ? -err_raw : err_raw;
		// small errors count as zero so the motor does not hunt
		err = (err_mag <= settings_i.deadband) ? '0 : err_raw;
		integ_sum = integ_q + err;
		if (integ_sum > settings_i.int_pos_max) begin
			integ_new = settings_i.int_pos_max;
		end else if (integ_sum < settings_i.int_neg_max) begin
			integ_new = settings_i.int_neg_max;
		end else begin
			integ_new = integ_sum;
		end
		// the integral term uses the integral after this update
		out_sum = settings_i.kp * err + settings_i.ki * integ_new;
		out_shift = out_sum >>> `MYO_GAIN_SHIFT;
		if (out_shift > settings_i.out_pos_max) begin
			out_new = settings_i.out_pos_max;
		end else if (out_shift < settings_i.out_neg_max) begin
			out_new = settings_i.out_neg_max;
		end else begin
			out_new = out_shift;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			integ_q <= '0;
			state_o <= '0;
		end else if (clear_i) begin
			// the position stays, only the control history goes
			integ_q <= '0;
			state_o.pwm <= '0;
		end else if (update_i) begin
			integ_q <= integ_new[`MYO_PARAM_W-1:0];
			state_o.pwm <= out_new[`MYO_PARAM_W-1:0];
			state_o.position <= position_i;
		end
	end

	a_pwm_in_limits: assert property (@(posedge clock) disable iff (reset)
		(update_i && !clear_i && settings_i.out_neg_max <= settings_i.out_pos_max) |=>
		(state_o.pwm <= $past(settings_i.out_pos_max) &&
		state_o.pwm >= $past(settings_i.out_neg_max)))
		else $error("PWM outside the output limits after an update");

endmodule

// ==== src/spi_frame_link.sv ====
// SPI master for the motor boards
// shifts one 32 bit full duplex frame, MSB first, SCK idle low,
// MOSI changes after falling edges and MISO is sampled on rising edges
`timescale 1ns/1ps
`include "myo_params.svh"

module spi_frame_link (
	input  logic clock,
	input  logic reset,
	input  logic start_i,
	input  logic [`MYO_MOTOR_W-1:0] motor_i,
	input  logic [`MYO_FRAME_W-1:0] tx_word_i,
	input  logic miso_i,
	output logic [`MYO_NUM_MOTORS-1:0] ss_n_o,
	output logic sck_o,
	output logic mosi_o,
	output logic frame_done_o,
	output logic signed [`MYO_POS_W-1:0] rx_position_o
);
	// two SCK half periods per bit
	localparam int HALVES = 2 * `MYO_FRAME_W;
	localparam int HALF_W = $clog2(HALVES);
	localparam int DIV_W = $clog2(`MYO_SCK_HALF + 1);

	logic active;
	logic [DIV_W-1:0] div_cnt;
	logic [HALF_W-1:0] half_cnt;
	logic half_end;
	logic last_half;
	logic [`MYO_FRAME_W-1:0] tx_sr;
	logic [`MYO_FRAME_W-1:0] rx_sr;
	logic [`MYO_NUM_MOTORS-1:0] ss_sel_n;

	assign half_end = div_cnt == DIV_W'(`MYO_SCK_HALF - 1);
	assign last_half = half_cnt == HALF_W'(HALVES - 1);
	// the first bit is already on MOSI when the select falls
	assign mosi_o = tx_sr[`MYO_FRAME_W-1];

	always_comb begin
		for (int i = 0; i < `MYO_NUM_MOTORS; i++) begin
			ss_sel_n[i] = motor_i != `MYO_MOTOR_W'(i);
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			div_cnt <= '0;
			half_cnt <= '0;
			sck_o <= 1'b0;
			ss_n_o <= '1;
			frame_done_o <= 1'b0;
		end else begin
			frame_done_o <= 1'b0;
			if (!active) begin
				if (start_i) begin
					active <= 1'b1;
					div_cnt <= '0;
					half_cnt <= '0;
					ss_n_o <= ss_sel_n;
				end
			end else if (!half_end) begin
				div_cnt <= div_cnt + 1'b1;
			end else if (last_half) begin
				// select and clock release together at the end of the frame
				active <= 1'b0;
				sck_o <= 1'b0;
				ss_n_o <= '1;
				frame_done_o <= 1'b1;
			end else begin
				div_cnt <= '0;
				half_cnt <= half_cnt + 1'b1;
				sck_o <= ~sck_o;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start_i && !active) begin
			tx_sr <= tx_word_i;
		end else if (active && half_end && sck_o) begin
			// the falling SCK edge shifts the next bit out
			tx_sr <= {tx_sr[`MYO_FRAME_W-2:0], 1'b0};
		end
		if (active && half_end && !sck_o) begin
			// the rising SCK edge samples the board
			rx_sr <= {rx_sr[`MYO_FRAME_W-2:0], miso_i};
		end
		// held until the next frame ends
		if (active && half_end && last_half) begin
			rx_position_o <= rx_sr;
		end
	end

	a_one_select: assert property (@(posedge clock) disable iff (reset)
		active |-> $onehot(~ss_n_o))
		else $error("frame running without exactly one motor board selected");

	a_no_restart: assert property (@(posedge clock) disable iff (reset) start_i |-> !active)
		else $error("frame start while a frame is in progress");

endmodule

// ==== src/scan_sequencer.sv ====
// scan sequencer of the motor control core
// walks the motors in order, starts one SPI frame per motor,
// spaces whole rounds by the update period and strobes the controller updates
`timescale 1ns/1ps
`include "myo_params.svh"

module scan_sequencer (
	input  logic clock,
	input  logic reset,
	input  logic scan_enable_i,
	input  logic [31:0] update_period_i,
	input  logic frame_done_i,
	input  myo_pkg::motor_state_t [`MYO_NUM_MOTORS-1:0] state_i,
	output logic start_o,
	output logic [`MYO_MOTOR_W-1:0] motor_o,
	output logic [`MYO_FRAME_W-1:0] tx_word_o,
	output logic [`MYO_NUM_MOTORS-1:0] update_o
);
	localparam int IDX_W = $clog2(`MYO_NUM_MOTORS);

	typedef enum logic [1:0] {S_IDLE, S_FRAME, S_WAIT} seq_state_t;

	seq_state_t state;
	logic [31:0] round_cnt;
	logic period_met;
	logic last_motor;

	// round_cnt holds the cycles since the last motor 0 start, so the
	// next start in the following cycle lands exactly one period later
	assign period_met = ({1'b0, round_cnt} + 33'd1) >= {1'b0, update_period_i};
	assign last_motor = motor_o == `MYO_MOTOR_W'(`MYO_NUM_MOTORS - 1);
	// PWM goes in the upper half of the frame and the lower half is zero
	assign tx_word_o = {state_i[motor_o[IDX_W-1:0]].pwm, {(`MYO_FRAME_W-`MYO_PARAM_W){1'b0}}};

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
			start_o <= 1'b0;
			motor_o <= '0;
			update_o <= '0;
			round_cnt <= '0;
		end else begin
			start_o <= 1'b0;
			update_o <= '0;
			if (start_o && motor_o == '0) begin
				round_cnt <= 32'd1;
			end else if (round_cnt != '1) begin
				round_cnt <= round_cnt + 32'd1;
			end
			case (state)
				S_IDLE: begin
					// a fresh scan always begins with motor 0 and no wait
					if (scan_enable_i) begin
						motor_o <= '0;
						start_o <= 1'b1;
						state <= S_FRAME;
					end
				end
				S_FRAME: begin
					if (frame_done_i) begin
						// the motor just served gets its controller update
						update_o[motor_o[IDX_W-1:0]] <= 1'b1;
						if (!scan_enable_i) begin
							motor_o <= '0;
							state <= S_IDLE;
						end else if (!last_motor) begin
							motor_o <= motor_o + 1'b1;
							start_o <= 1'b1;
						end else if (period_met) begin
							motor_o <= '0;
							start_o <= 1'b1;
						end else begin
							motor_o <= '0;
							state <= S_WAIT;
						end
					end
				end
				S_WAIT: begin
					if (!scan_enable_i) begin
						state <= S_IDLE;
					end else if (period_met) begin
						start_o <= 1'b1;
						state <= S_FRAME;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_done_in_frame: assert property (@(posedge clock) disable iff (reset)
		frame_done_i |-> state == S_FRAME)
		else $error("frame done reported while no frame was started");

endmodule

// ==== src/myo_reg_bank.sv ====
// host register file of the motor control core
// per-motor PI settings, scan enable and update period
// write decode, controller clear strobes and the registered read mux
`timescale 1ns/1ps
`include "myo_params.svh"

module myo_reg_bank (
	input  logic clock,
	input  logic reset,
	input  myo_pkg::bus_req_t bus_i,
	input  myo_pkg::motor_state_t [`MYO_NUM_MOTORS-1:0] state_i,
	output logic [31:0] readdata_o,
	output logic read_valid_o,
	output myo_pkg::pi_settings_t [`MYO_NUM_MOTORS-1:0] settings_o,
	output logic [`MYO_NUM_MOTORS-1:0] ctrl_clear_o,
	output logic scan_enable_o,
	output logic [31:0] update_period_o
);
	import myo_pkg::*;

	localparam int IDX_W = $clog2(`MYO_NUM_MOTORS);

	logic [15-`MYO_MOTOR_W:0] sel;
	logic [`MYO_MOTOR_W-1:0] motor;
	logic [IDX_W-1:0] idx;
	logic in_range;
	pi_settings_t [`MYO_NUM_MOTORS-1:0] settings_q;
	pi_settings_t cur;
	motor_state_t cur_state;
	logic [31:0] read_mux;

	// 16 bit fields read back as signed 32 bit words
	function automatic logic [31:0] sext_param(input logic [`MYO_PARAM_W-1:0] v);
		return {{(32-`MYO_PARAM_W){v[`MYO_PARAM_W-1]}}, v};
	endfunction

	assign sel = bus_i.address[15:`MYO_MOTOR_W];
	assign motor = bus_i.address[`MYO_MOTOR_W-1:0];
	assign idx = motor[IDX_W-1:0];
	// motor bytes past the last board select nothing
	assign in_range = motor < `MYO_MOTOR_W'(`MYO_NUM_MOTORS);
	assign cur = settings_q[idx];
	assign cur_state = state_i[idx];
	assign settings_o = settings_q;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			settings_q <= '0;
			ctrl_clear_o <= '0;
			scan_enable_o <= 1'b0;
			update_period_o <= '0;
		end else begin
			// the clear is a strobe, so it drops again after one cycle
			ctrl_clear_o <= '0;
			if (bus_i.write) begin
				if (in_range) begin
					case (sel)
						`MYO_SEL_KP: settings_q[idx].kp <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_KI: settings_q[idx].ki <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_SP: settings_q[idx].sp <= bus_i.writedata;
						`MYO_SEL_OUT_POS_MAX:
							settings_q[idx].out_pos_max <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_OUT_NEG_MAX:
							settings_q[idx].out_neg_max <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_INT_POS_MAX:
							settings_q[idx].int_pos_max <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_INT_NEG_MAX:
							settings_q[idx].int_neg_max <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_DEADBAND:
							settings_q[idx].deadband <= bus_i.writedata[`MYO_PARAM_W-1:0];
						`MYO_SEL_CTRL_RESET: ctrl_clear_o[idx] <= bus_i.writedata != '0;
						default: ;
					endcase
				end
				case (sel)
					`MYO_SEL_SCAN_ENABLE: scan_enable_o <= bus_i.writedata != '0;
					`MYO_SEL_UPDATE_PERIOD: update_period_o <= bus_i.writedata;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		read_mux = `MYO_BAD_READ;
		if (in_range) begin
			case (sel)
				`MYO_SEL_KP: read_mux = sext_param(cur.kp);
				`MYO_SEL_KI: read_mux = sext_param(cur.ki);
				`MYO_SEL_SP: read_mux = cur.sp;
				`MYO_SEL_OUT_POS_MAX: read_mux = sext_param(cur.out_pos_max);
				`MYO_SEL_OUT_NEG_MAX: read_mux = sext_param(cur.out_neg_max);
				`MYO_SEL_INT_POS_MAX: read_mux = sext_param(cur.int_pos_max);
				`MYO_SEL_INT_NEG_MAX: read_mux = sext_param(cur.int_neg_max);
				`MYO_SEL_DEADBAND: read_mux = sext_param(cur.deadband);
				`MYO_SEL_POSITION: read_mux = cur_state.position;
				`MYO_SEL_PWM: read_mux = sext_param(cur_state.pwm);
				default: ;
			endcase
		end
		// global registers answer whatever the motor byte holds
		case (sel)
			`MYO_SEL_SCAN_ENABLE: read_mux = {31'b0, scan_enable_o};
			`MYO_SEL_UPDATE_PERIOD: read_mux = update_period_o;
			default: ;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			read_valid_o <= 1'b0;
		end else begin
			read_valid_o <= bus_i.read;
		end
	end

	// read data is only meaningful while read_valid_o is high
	always_ff @(posedge clock) begin
		if (bus_i.read) begin
			readdata_o <= read_mux;
		end
	end

	a_read_answered: assert property (@(posedge clock) disable iff (reset)
		bus_i.read |=> read_valid_o && !$isunknown(readdata_o))
		else $error("read strobe was not answered with known data one cycle later");

endmodule

// ==== src/myo_pkg.sv ====
// shared types of the motor control core
// per-motor controller settings, per-motor state and the host request
`include "myo_params.svh"

package myo_pkg;

	// one motor's PI settings as written by the host
	// everything is 16 bits except the 32 bit setpoint
	typedef struct packed {
		logic signed [`MYO_PARAM_W-1:0] kp;
		logic signed [`MYO_PARAM_W-1:0] ki;
		logic signed [`MYO_POS_W-1:0] sp;
		logic signed [`MYO_PARAM_W-1:0] out_pos_max;
		logic signed [`MYO_PARAM_W-1:0] out_neg_max;
		logic signed [`MYO_PARAM_W-1:0] int_pos_max;
		logic signed [`MYO_PARAM_W-1:0] int_neg_max;
		logic signed [`MYO_PARAM_W-1:0] deadband;
	} pi_settings_t;

	// last position received from the board and the PWM that goes out next
	typedef struct packed {
		logic signed [`MYO_POS_W-1:0] position;
		logic signed [`MYO_PARAM_W-1:0] pwm;
	} motor_state_t;

	// host request, both strobes are single cycle
	// address holds the select in the upper byte and the motor in the lower byte
	typedef struct packed {
		logic read;
		logic write;
		logic [15:0] address;
		logic [31:0] writedata;
	} bus_req_t;

endpackage

// ==== src/myo_params.svh ====
// constants shared by the motor control core
// motor count and data widths, SPI timing and controller gain shift
// host register selects and the value returned for a bad read
`ifndef MYO_PARAMS_SVH
`define MYO_PARAMS_SVH

`define MYO_NUM_MOTORS 4
`define MYO_MOTOR_W 8
`define MYO_POS_W 32
`define MYO_PARAM_W 16
`define MYO_FRAME_W 32
`define MYO_SCK_HALF 2
`define MYO_GAIN_SHIFT 4

// per-motor selects live in the upper address byte
`define MYO_SEL_KP 8'h00
`define MYO_SEL_KI 8'h01
`define MYO_SEL_SP 8'h02
`define MYO_SEL_OUT_POS_MAX 8'h03
`define MYO_SEL_OUT_NEG_MAX 8'h04
`define MYO_SEL_INT_POS_MAX 8'h05
`define MYO_SEL_INT_NEG_MAX 8'h06
`define MYO_SEL_DEADBAND 8'h07
`define MYO_SEL_POSITION 8'h08
`define MYO_SEL_PWM 8'h09
`define MYO_SEL_CTRL_RESET 8'h0A
// global selects ignore the motor byte
`define MYO_SEL_SCAN_ENABLE 8'h10
`define MYO_SEL_UPDATE_PERIOD 8'h11

`define MYO_BAD_READ 32'hDEADBEEF

`endif
